//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = ex_stage_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/ex_alu.sv
`default_nettype none

module ex_alu
    import ex_pkg::*;
(
    input  logic [alu_op_width-1:0]  op_i,
    input  logic [alu_sel_width-1:0] sel_i,
    input  logic [reg_width-1:0]     opnd1_i,
    input  logic [reg_width-1:0]     opnd2_i,
    input  logic [reg_width-1:0]     instr_i,
    input  logic [reg_width-1:0]     pc_i,
    input  logic [reg_width-1:0]     csr_data_i,
    output logic [reg_width-1:0]     wdata_o,
    output logic [reg_width-1:0]     mem_addr_o,
    output logic [reg_width-1:0]     csr_wdata_o
);

    instr_word_u                   instr;
    logic [reg_width-1:0]          logic_res;
    logic [reg_width-1:0]          shift_res;
    logic [reg_width-1:0]          move_res;
    logic [reg_width-1:0]          arith_res;
    logic                          mul_signed;
    logic signed [reg_width:0]     mul_a;
    logic signed [reg_width:0]     mul_b;
    logic signed [2*reg_width+1:0] product;

    assign instr = instr_i;

    assign mem_addr_o = opnd1_i + {{(reg_width-12){instr.ri12.imm12[11]}}, instr.ri12.imm12};

    // set bits of the opnd2 mask take opnd1
    assign csr_wdata_o = (op_i == op_csrxchg) ?
                         ((opnd1_i & opnd2_i) | (csr_data_i & ~opnd2_i)) : csr_data_i;

    // one 33x33 signed multiplier covers both signed and unsigned products
    assign mul_signed = (op_i != op_mulhu);
    assign mul_a      = {mul_signed & opnd1_i[reg_width-1], opnd1_i};
    assign mul_b      = {mul_signed & opnd2_i[reg_width-1], opnd2_i};
    assign product    = mul_a * mul_b;

    always_comb begin
        case (op_i)
            op_or:   logic_res = opnd1_i | opnd2_i;
            op_and:  logic_res = opnd1_i & opnd2_i;
            op_xor:  logic_res = opnd1_i ^ opnd2_i;
            op_nor:  logic_res = ~(opnd1_i | opnd2_i);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            op_sll:  shift_res = opnd1_i << opnd2_i[4:0];
            op_srl:  shift_res = opnd1_i >> opnd2_i[4:0];
            op_sra:  shift_res = $unsigned($signed(opnd1_i) >>> opnd2_i[4:0]);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            op_lui:   move_res = opnd2_i;
            op_pcadd: move_res = pc_i + opnd2_i;
            default:  move_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            op_add:  arith_res = opnd1_i + opnd2_i;
            op_sub:  arith_res = opnd1_i - opnd2_i;
            op_slt:  arith_res = {{(reg_width-1){1'b0}}, $signed(opnd1_i) < $signed(opnd2_i)};
            op_sltu: arith_res = {{(reg_width-1){1'b0}}, opnd1_i < opnd2_i};
            op_mul:  arith_res = product[reg_width-1:0];
            op_mulh, op_mulhu: begin
                arith_res = product[2*reg_width-1:reg_width];
            end
            default: arith_res = '0;
        endcase
    end

    always_comb begin
        case (sel_i)
            sel_none:  wdata_o = '0;
            sel_logic: wdata_o = logic_res;
            sel_shift: wdata_o = shift_res;
            sel_move:  wdata_o = move_res;
            sel_arith: wdata_o = arith_res;
            // link address
            sel_jump:  wdata_o = pc_i + 32'd4;
            default:   wdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ex_branch.sv
`default_nettype none

module ex_branch
    import ex_pkg::*;
(
    input  logic [alu_op_width-1:0] op_i,
    input  logic [reg_width-1:0]    opnd1_i,
    input  logic [reg_width-1:0]    opnd2_i,
    input  logic [reg_width-1:0]    instr_i,
    input  logic [reg_width-1:0]    pc_i,
    output logic                    branch_o,
    output logic [reg_width-1:0]    target_o
);

    instr_word_u          instr;
    logic [reg_width-1:0] offs;
    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;

    assign instr = instr_i;

    // word offset, sign-extended
    assign offs = {{(reg_width-18){instr.ri16.offs16[15]}}, instr.ri16.offs16, 2'b00};

    assign eq   = (opnd1_i == opnd2_i);
    assign lt_s = ($signed(opnd1_i) < $signed(opnd2_i));
    assign lt_u = (opnd1_i < opnd2_i);

    always_comb begin
        branch_o = 1'b0;
        target_o = '0;
        case (op_i)
            op_b, op_bl: begin
                branch_o = 1'b1;
                target_o = pc_i + opnd2_i;
            end
            op_jirl: begin
                branch_o = 1'b1;
                target_o = opnd1_i + offs;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                target_o = pc_i + offs;
                case (op_i)
                    op_beq:  branch_o = eq;
                    op_bne:  branch_o = ~eq;
                    op_blt:  branch_o = lt_s;
                    op_bge:  branch_o = ~lt_s;
                    op_bltu: branch_o = lt_u;
                    default: branch_o = ~lt_u;
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ex_dispatch_reg.sv
`default_nettype none

module ex_dispatch_reg
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_i,

    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic [alu_op_width-1:0]   in_op_i,
    input  logic [alu_sel_width-1:0]  in_sel_i,
    input  logic [reg_width-1:0]      in_opnd1_i,
    input  logic [reg_width-1:0]      in_opnd2_i,
    input  logic [reg_width-1:0]      in_instr_i,
    input  logic [reg_width-1:0]      in_pc_i,
    input  logic [reg_addr_width-1:0] in_waddr_i,
    input  logic                      in_wreg_i,
    input  logic                      in_csr_we_i,
    input  logic [csr_addr_width-1:0] in_csr_addr_i,
    input  logic [reg_width-1:0]      in_csr_data_i,

    input  logic                      down_ready_i,
    output logic                      hold_valid_o,
    output logic [alu_op_width-1:0]   hold_op_o,
    output logic [alu_sel_width-1:0]  hold_sel_o,
    output logic [reg_width-1:0]      hold_opnd1_o,
    output logic [reg_width-1:0]      hold_opnd2_o,
    output logic [reg_width-1:0]      hold_instr_o,
    output logic [reg_width-1:0]      hold_pc_o,
    output logic [reg_addr_width-1:0] hold_waddr_o,
    output logic                      hold_wreg_o,
    output logic                      hold_csr_we_o,
    output logic [csr_addr_width-1:0] hold_csr_addr_o,
    output logic [reg_width-1:0]      hold_csr_data_o
);

    // keeps ready low while reset is applied
    logic run_q;

    assign in_ready_o = run_q & (~hold_valid_o | down_ready_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q        <= 1'b0;
            hold_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (in_ready_o) begin
                hold_valid_o <= in_valid_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            hold_op_o       <= in_op_i;
            hold_sel_o      <= in_sel_i;
            hold_opnd1_o    <= in_opnd1_i;
            hold_opnd2_o    <= in_opnd2_i;
            hold_instr_o    <= in_instr_i;
            hold_pc_o       <= in_pc_i;
            hold_waddr_o    <= in_waddr_i;
            hold_wreg_o     <= in_wreg_i;
            hold_csr_we_o   <= in_csr_we_i;
            hold_csr_addr_o <= in_csr_addr_i;
            hold_csr_data_o <= in_csr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_i,

    input  logic                      up_valid_i,
    output logic                      up_ready_o,
    input  logic [reg_width-1:0]      up_wdata_i,
    input  logic [reg_addr_width-1:0] up_waddr_i,
    input  logic                      up_wreg_i,
    input  logic [reg_width-1:0]      up_mem_addr_i,
    input  logic [reg_width-1:0]      up_opnd2_i,
    input  logic [alu_op_width-1:0]   up_op_i,
    input  logic                      up_csr_we_i,
    input  logic [csr_addr_width-1:0] up_csr_addr_i,
    input  logic [reg_width-1:0]      up_csr_data_i,
    input  logic                      up_branch_i,
    input  logic [reg_width-1:0]      up_target_i,
    input  logic [reg_width-1:0]      up_pc_i,

    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [reg_width-1:0]      out_wdata_o,
    output logic [reg_addr_width-1:0] out_waddr_o,
    output logic                      out_wreg_o,
    output logic [reg_width-1:0]      out_mem_addr_o,
    output logic [reg_width-1:0]      out_opnd2_o,
    output logic [alu_op_width-1:0]   out_op_o,
    output logic                      out_csr_we_o,
    output logic [csr_addr_width-1:0] out_csr_addr_o,
    output logic [reg_width-1:0]      out_csr_data_o,
    output logic                      out_branch_o,
    output logic [reg_width-1:0]      out_target_o,
    output logic [reg_width-1:0]      out_pc_o
);

    assign up_ready_o = ~out_valid_o | out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (up_ready_o) begin
            out_valid_o <= up_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (up_valid_i && up_ready_o) begin
            out_wdata_o    <= up_wdata_i;
            out_waddr_o    <= up_waddr_i;
            out_wreg_o     <= up_wreg_i;
            out_mem_addr_o <= up_mem_addr_i;
            out_opnd2_o    <= up_opnd2_i;
            out_op_o       <= up_op_i;
            out_csr_we_o   <= up_csr_we_i;
            out_csr_addr_o <= up_csr_addr_i;
            out_csr_data_o <= up_csr_data_i;
            out_branch_o   <= up_branch_i;
            out_target_o   <= up_target_i;
            out_pc_o       <= up_pc_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int unsigned reg_width      = 32;
    localparam int unsigned reg_addr_width = 5;
    localparam int unsigned csr_addr_width = 14;
    localparam int unsigned alu_op_width   = 6;
    localparam int unsigned alu_sel_width  = 3;

    // logic
    localparam logic [alu_op_width-1:0] op_or      = 6'h01;
    localparam logic [alu_op_width-1:0] op_and     = 6'h02;
    localparam logic [alu_op_width-1:0] op_xor     = 6'h03;
    localparam logic [alu_op_width-1:0] op_nor     = 6'h04;
    // shift
    localparam logic [alu_op_width-1:0] op_sll     = 6'h05;
    localparam logic [alu_op_width-1:0] op_srl     = 6'h06;
    localparam logic [alu_op_width-1:0] op_sra     = 6'h07;
    // move
    localparam logic [alu_op_width-1:0] op_lui     = 6'h08;
    localparam logic [alu_op_width-1:0] op_pcadd   = 6'h09;
    // arithmetic
    localparam logic [alu_op_width-1:0] op_add     = 6'h0a;
    localparam logic [alu_op_width-1:0] op_sub     = 6'h0b;
    localparam logic [alu_op_width-1:0] op_slt     = 6'h0c;
    localparam logic [alu_op_width-1:0] op_sltu    = 6'h0d;
    localparam logic [alu_op_width-1:0] op_mul     = 6'h0e;
    localparam logic [alu_op_width-1:0] op_mulh    = 6'h0f;
    localparam logic [alu_op_width-1:0] op_mulhu   = 6'h10;
    // jumps and branches
    localparam logic [alu_op_width-1:0] op_b       = 6'h11;
    localparam logic [alu_op_width-1:0] op_bl      = 6'h12;
    localparam logic [alu_op_width-1:0] op_jirl    = 6'h13;
    localparam logic [alu_op_width-1:0] op_beq     = 6'h14;
    localparam logic [alu_op_width-1:0] op_bne     = 6'h15;
    localparam logic [alu_op_width-1:0] op_blt     = 6'h16;
    localparam logic [alu_op_width-1:0] op_bge     = 6'h17;
    localparam logic [alu_op_width-1:0] op_bltu    = 6'h18;
    localparam logic [alu_op_width-1:0] op_bgeu    = 6'h19;
    localparam logic [alu_op_width-1:0] op_csrxchg = 6'h1a;
    // load/store, address only
    localparam logic [alu_op_width-1:0] op_mem    = 6'h1b;

    localparam logic [alu_sel_width-1:0] sel_none  = 3'd0;
    localparam logic [alu_sel_width-1:0] sel_logic = 3'd1;
    localparam logic [alu_sel_width-1:0] sel_shift = 3'd2;
    localparam logic [alu_sel_width-1:0] sel_move  = 3'd3;
    localparam logic [alu_sel_width-1:0] sel_arith = 3'd4;
    localparam logic [alu_sel_width-1:0] sel_jump  = 3'd5;

    typedef struct packed {
        logic [9:0]                opcode;
        logic [11:0]               imm12;
        logic [reg_addr_width-1:0] rj;
        logic [reg_addr_width-1:0] rd;
    } ri12_t;

    // branch and jirl format
    typedef struct packed {
        logic [5:0]                opcode;
        logic [15:0]               offs16;
        logic [reg_addr_width-1:0] rj;
        logic [reg_addr_width-1:0] rd;
    } ri16_t;

    typedef union packed {
        ri12_t ri12;
        ri16_t ri16;
    } instr_word_u;

endpackage

`default_nettype wire

//--- logic/ex_stage.sv
`default_nettype none

module ex_stage
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_i,

    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic [alu_op_width-1:0]   in_op_i,
    input  logic [alu_sel_width-1:0]  in_sel_i,
    input  logic [reg_width-1:0]      in_opnd1_i,
    input  logic [reg_width-1:0]      in_opnd2_i,
    input  logic [reg_width-1:0]      in_instr_i,
    input  logic [reg_width-1:0]      in_pc_i,
    input  logic [reg_addr_width-1:0] in_waddr_i,
    input  logic                      in_wreg_i,
    input  logic                      in_csr_we_i,
    input  logic [csr_addr_width-1:0] in_csr_addr_i,
    input  logic [reg_width-1:0]      in_csr_data_i,

    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    output logic [reg_width-1:0]      out_wdata_o,
    output logic [reg_addr_width-1:0] out_waddr_o,
    output logic                      out_wreg_o,
    output logic [reg_width-1:0]      out_mem_addr_o,
    output logic [reg_width-1:0]      out_opnd2_o,
    output logic [alu_op_width-1:0]   out_op_o,
    output logic                      out_csr_we_o,
    output logic [csr_addr_width-1:0] out_csr_addr_o,
    output logic [reg_width-1:0]      out_csr_data_o,
    output logic                      out_branch_o,
    output logic [reg_width-1:0]      out_target_o,
    output logic [reg_width-1:0]      out_pc_o
);

    logic                      hold_valid;
    logic                      mem_ready;
    logic [alu_op_width-1:0]   hold_op;
    logic [alu_sel_width-1:0]  hold_sel;
    logic [reg_width-1:0]      hold_opnd1;
    logic [reg_width-1:0]      hold_opnd2;
    logic [reg_width-1:0]      hold_instr;
    logic [reg_width-1:0]      hold_pc;
    logic [reg_addr_width-1:0] hold_waddr;
    logic                      hold_wreg;
    logic                      hold_csr_we;
    logic [csr_addr_width-1:0] hold_csr_addr;
    logic [reg_width-1:0]      hold_csr_data;

    logic [reg_width-1:0]      alu_wdata;
    logic [reg_width-1:0]      alu_mem_addr;
    logic [reg_width-1:0]      alu_csr_wdata;
    logic                      br_taken;
    logic [reg_width-1:0]      br_target;

    ex_dispatch_reg dispatch_reg_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_op_i         (in_op_i),
        .in_sel_i        (in_sel_i),
        .in_opnd1_i      (in_opnd1_i),
        .in_opnd2_i      (in_opnd2_i),
        .in_instr_i      (in_instr_i),
        .in_pc_i         (in_pc_i),
        .in_waddr_i      (in_waddr_i),
        .in_wreg_i       (in_wreg_i),
        .in_csr_we_i     (in_csr_we_i),
        .in_csr_addr_i   (in_csr_addr_i),
        .in_csr_data_i   (in_csr_data_i),
        .down_ready_i    (mem_ready),
        .hold_valid_o    (hold_valid),
        .hold_op_o       (hold_op),
        .hold_sel_o      (hold_sel),
        .hold_opnd1_o    (hold_opnd1),
        .hold_opnd2_o    (hold_opnd2),
        .hold_instr_o    (hold_instr),
        .hold_pc_o       (hold_pc),
        .hold_waddr_o    (hold_waddr),
        .hold_wreg_o     (hold_wreg),
        .hold_csr_we_o   (hold_csr_we),
        .hold_csr_addr_o (hold_csr_addr),
        .hold_csr_data_o (hold_csr_data)
    );

    ex_alu alu_i (
        .op_i        (hold_op),
        .sel_i       (hold_sel),
        .opnd1_i     (hold_opnd1),
        .opnd2_i     (hold_opnd2),
        .instr_i     (hold_instr),
        .pc_i        (hold_pc),
        .csr_data_i  (hold_csr_data),
        .wdata_o     (alu_wdata),
        .mem_addr_o  (alu_mem_addr),
        .csr_wdata_o (alu_csr_wdata)
    );

    ex_branch branch_i (
        .op_i     (hold_op),
        .opnd1_i  (hold_opnd1),
        .opnd2_i  (hold_opnd2),
        .instr_i  (hold_instr),
        .pc_i     (hold_pc),
        .branch_o (br_taken),
        .target_o (br_target)
    );

    ex_mem_reg mem_reg_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .up_valid_i     (hold_valid),
        .up_ready_o     (mem_ready),
        .up_wdata_i     (alu_wdata),
        .up_waddr_i     (hold_waddr),
        .up_wreg_i      (hold_wreg),
        .up_mem_addr_i  (alu_mem_addr),
        .up_opnd2_i     (hold_opnd2),
        .up_op_i        (hold_op),
        .up_csr_we_i    (hold_csr_we),
        .up_csr_addr_i  (hold_csr_addr),
        .up_csr_data_i  (alu_csr_wdata),
        .up_branch_i    (br_taken),
        .up_target_i    (br_target),
        .up_pc_i        (hold_pc),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_wdata_o    (out_wdata_o),
        .out_waddr_o    (out_waddr_o),
        .out_wreg_o     (out_wreg_o),
        .out_mem_addr_o (out_mem_addr_o),
        .out_opnd2_o    (out_opnd2_o),
        .out_op_o       (out_op_o),
        .out_csr_we_o   (out_csr_we_o),
        .out_csr_addr_o (out_csr_addr_o),
        .out_csr_data_o (out_csr_data_o),
        .out_branch_o   (out_branch_o),
        .out_target_o   (out_target_o),
        .out_pc_o       (out_pc_o)
    );

endmodule

`default_nettype wire

//--- tests/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb
    import ex_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [reg_width-1:0] pc_base = 32'h1c00_0100;

    // offs16 = 8, imm12 = 8
    localparam logic [reg_width-1:0] ins_fwd8  = 32'h0000_2000;
    // offs16 = -4, imm12 = -4
    localparam logic [reg_width-1:0] ins_back4 = 32'h03ff_f000;
    // offs16 = 16, imm12 = 16
    localparam logic [reg_width-1:0] ins_p16   = 32'h0000_4000;
    localparam logic [reg_width-1:0] ins_m8    = 32'h003f_e000;
    localparam logic [reg_width-1:0] ins_max   = 32'h001f_fc00;

    typedef struct packed {
        logic [alu_op_width-1:0]  op;
        logic [alu_sel_width-1:0] sel;
        logic [reg_width-1:0]     opnd1;
        logic [reg_width-1:0]     opnd2;
        logic [reg_width-1:0]     instr;
        logic                     csr_we;
        logic [reg_width-1:0]     csr_data;
        logic [reg_width-1:0]     wdata;
        logic [reg_width-1:0]     mem_addr;
        logic [reg_width-1:0]     csr_wdata;
        logic                     branch;
        logic [reg_width-1:0]     target;
    } row_t;

    logic                      clk;
    logic                      reset_i;
    logic                      in_valid_i;
    logic                      in_ready_o;
    logic [alu_op_width-1:0]   in_op_i;
    logic [alu_sel_width-1:0]  in_sel_i;
    logic [reg_width-1:0]      in_opnd1_i;
    logic [reg_width-1:0]      in_opnd2_i;
    logic [reg_width-1:0]      in_instr_i;
    logic [reg_width-1:0]      in_pc_i;
    logic [reg_addr_width-1:0] in_waddr_i;
    logic                      in_wreg_i;
    logic                      in_csr_we_i;
    logic [csr_addr_width-1:0] in_csr_addr_i;
    logic [reg_width-1:0]      in_csr_data_i;
    logic                      out_valid_o;
    logic                      out_ready_i;
    logic [reg_width-1:0]      out_wdata_o;
    logic [reg_addr_width-1:0] out_waddr_o;
    logic                      out_wreg_o;
    logic [reg_width-1:0]      out_mem_addr_o;
    logic [reg_width-1:0]      out_opnd2_o;
    logic [alu_op_width-1:0]   out_op_o;
    logic                      out_csr_we_o;
    logic [csr_addr_width-1:0] out_csr_addr_o;
    logic [reg_width-1:0]      out_csr_data_o;
    logic                      out_branch_o;
    logic [reg_width-1:0]      out_target_o;
    logic [reg_width-1:0]      out_pc_o;

    row_t rows[$];
    int   out_count = 0;
    int   cycles = 0;
    int   cycle_limit = 1000;

    ex_stage ex_stage_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_op_i        (in_op_i),
        .in_sel_i       (in_sel_i),
        .in_opnd1_i     (in_opnd1_i),
        .in_opnd2_i     (in_opnd2_i),
        .in_instr_i     (in_instr_i),
        .in_pc_i        (in_pc_i),
        .in_waddr_i     (in_waddr_i),
        .in_wreg_i      (in_wreg_i),
        .in_csr_we_i    (in_csr_we_i),
        .in_csr_addr_i  (in_csr_addr_i),
        .in_csr_data_i  (in_csr_data_i),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_wdata_o    (out_wdata_o),
        .out_waddr_o    (out_waddr_o),
        .out_wreg_o     (out_wreg_o),
        .out_mem_addr_o (out_mem_addr_o),
        .out_opnd2_o    (out_opnd2_o),
        .out_op_o       (out_op_o),
        .out_csr_we_o   (out_csr_we_o),
        .out_csr_addr_o (out_csr_addr_o),
        .out_csr_data_o (out_csr_data_o),
        .out_branch_o   (out_branch_o),
        .out_target_o   (out_target_o),
        .out_pc_o       (out_pc_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, want);
            $display("Done: errors found");
            $fatal(1, "output check failed");
        end
    endtask

    function automatic void add_row(
        input logic [alu_op_width-1:0]  op,
        input logic [alu_sel_width-1:0] sel,
        input logic [reg_width-1:0]     a,
        input logic [reg_width-1:0]     b,
        input logic [reg_width-1:0]     instr,
        input logic [reg_width-1:0]     wdata,
        input logic [reg_width-1:0]     mem_addr,
        input logic                     branch,
        input logic [reg_width-1:0]     target
    );
        row_t r;
        r.op        = op;
        r.sel       = sel;
        r.opnd1     = a;
        r.opnd2     = b;
        r.instr     = instr;
        r.csr_we    = 1'b0;
        r.csr_data  = '0;
        r.wdata     = wdata;
        r.mem_addr  = mem_addr;
        r.csr_wdata = '0;
        r.branch    = branch;
        r.target    = target;
        rows.push_back(r);
    endfunction

    // turns the last row into a CSR write
    function automatic void set_csr(input logic [reg_width-1:0] old_data,
                                    input logic [reg_width-1:0] new_data);
        row_t r;
        r = rows.pop_back();
        r.csr_we    = 1'b1;
        r.csr_data  = old_data;
        r.csr_wdata = new_data;
        rows.push_back(r);
    endfunction

    // pc is pc_base for every row
    function automatic void build_table();
        add_row(op_or,    sel_logic, 'h0f0f00ff, 'h00ff0f0f, 0, 'h0fff0fff, 'h0f0f00ff, 1'b0, 0);
        add_row(op_and,   sel_logic, 'h0f0f00ff, 'h00ff0f0f, 0, 'h000f000f, 'h0f0f00ff, 1'b0, 0);
        add_row(op_xor,   sel_logic, 'h0f0f00ff, 'h00ff0f0f, 0, 'h0ff00ff0, 'h0f0f00ff, 1'b0, 0);
        add_row(op_nor,   sel_logic, 'h0f0f00ff, 'h00ff0f0f, 0, 'hf000f000, 'h0f0f00ff, 1'b0, 0);
        // shift amount 0x24 uses only its low 5 bits
        add_row(op_sll,   sel_shift, 'h80000001, 'h24, 0, 'h00000010, 'h80000001, 1'b0, 0);
        add_row(op_srl,   sel_shift, 'h80000010, 'h4, 0, 'h08000001, 'h80000010, 1'b0, 0);
        add_row(op_sra,   sel_shift, 'h80000010, 'h4, 0, 'hf8000001, 'h80000010, 1'b0, 0);
        add_row(op_lui,   sel_move,  0, 'h12345000, 0, 'h12345000, 0, 1'b0, 0);
        add_row(op_pcadd, sel_move,  0, 'h2000, 0, 'h1c002100, 0, 1'b0, 0);
        add_row(op_add,   sel_arith, 'hfffffff0, 'h20, 0, 'h10, 'hfffffff0, 1'b0, 0);
        add_row(op_sub,   sel_arith, 'h5, 'h7, 0, 'hfffffffe, 'h5, 1'b0, 0);
        add_row(op_slt,   sel_arith, 'hffffffff, 'h1, 0, 'h1, 'hffffffff, 1'b0, 0);
        add_row(op_sltu,  sel_arith, 'hffffffff, 'h1, 0, 'h0, 'hffffffff, 1'b0, 0);
        add_row(op_slt,   sel_arith, 'h1, 'hffffffff, 0, 'h0, 'h1, 1'b0, 0);
        add_row(op_sltu,  sel_arith, 'h1, 'hffffffff, 0, 'h1, 'h1, 1'b0, 0);
        // -3 * 7 and -3 * -5
        add_row(op_mul,   sel_arith, 'hfffffffd, 'h7, 0, 'hffffffeb, 'hfffffffd, 1'b0, 0);
        add_row(op_mulh,  sel_arith, 'hfffffffd, 'h7, 0, 'hffffffff, 'hfffffffd, 1'b0, 0);
        add_row(op_mul,   sel_arith, 'hfffffffd, 'hfffffffb, 0, 'hf, 'hfffffffd, 1'b0, 0);
        add_row(op_mulh,  sel_arith, 'h80000000, 'h80000000, 0, 'h40000000, 'h80000000, 1'b0, 0);
        add_row(op_mulhu, sel_arith, 'hffffffff, 'hffffffff, 0, 'hfffffffe, 'hffffffff, 1'b0, 0);
        add_row(op_mulhu, sel_arith, 'h80000000, 'h2, 0, 'h1, 'h80000000, 1'b0, 0);
        add_row(op_mulh,  sel_arith, 'h80000000, 'h2, 0, 'hffffffff, 'h80000000, 1'b0, 0);
        add_row(op_b,  sel_none, 0, 'h400, 0, 0, 0, 1'b1, 'h1c000500);
        add_row(op_bl, sel_jump, 0, 'hfffffff0, 0, 'h1c000104, 0, 1'b1, 'h1c0000f0);
        add_row(op_jirl, sel_jump, 'h1c008000, 0, ins_p16, 'h1c000104,
                'h1c008010, 1'b1, 'h1c008040);
        add_row(op_jirl, sel_jump, 'h1c008000, 0, ins_back4, 'h1c000104,
                'h1c007ffc, 1'b1, 'h1c007ff0);
        // not-taken branches still report the target
        add_row(op_beq,  sel_none, 'h5, 'h5, ins_fwd8, 0, 'hd, 1'b1, 'h1c000120);
        add_row(op_beq,  sel_none, 'h5, 'h6, ins_fwd8, 0, 'hd, 1'b0, 'h1c000120);
        add_row(op_bne,  sel_none, 'h5, 'h6, ins_back4, 0, 'h1, 1'b1, 'h1c0000f0);
        add_row(op_bne,  sel_none, 'h5, 'h5, ins_back4, 0, 'h1, 1'b0, 'h1c0000f0);
        add_row(op_blt,  sel_none, 'hffffffff, 'h1, ins_fwd8, 0, 'h7, 1'b1, 'h1c000120);
        add_row(op_blt,  sel_none, 'h1, 'hffffffff, ins_fwd8, 0, 'h9, 1'b0, 'h1c000120);
        add_row(op_bge,  sel_none, 'h1, 'hffffffff, ins_fwd8, 0, 'h9, 1'b1, 'h1c000120);
        add_row(op_bge,  sel_none, 'hffffffff, 'h1, ins_fwd8, 0, 'h7, 1'b0, 'h1c000120);
        add_row(op_bltu, sel_none, 'h1, 'hffffffff, ins_fwd8, 0, 'h9, 1'b1, 'h1c000120);
        add_row(op_bltu, sel_none, 'hffffffff, 'h1, ins_fwd8, 0, 'h7, 1'b0, 'h1c000120);
        add_row(op_bgeu, sel_none, 'hffffffff, 'h1, ins_fwd8, 0, 'h7, 1'b1, 'h1c000120);
        add_row(op_bgeu, sel_none, 'h1, 'hffffffff, ins_fwd8, 0, 'h9, 1'b0, 'h1c000120);
        add_row(op_mem, sel_none, 'h1000, 'hcafe0001, ins_p16, 0, 'h1010, 1'b0, 0);
        add_row(op_mem, sel_none, 'h1000, 'hcafe0002, ins_m8, 0, 'h0ff8, 1'b0, 0);
        add_row(op_mem, sel_none, 'h1000, 'hcafe0003, ins_max, 0, 'h17ff, 1'b0, 0);
        add_row(op_csrxchg, sel_none, 'haaaa5555, 'hff00ff00, 0, 0, 'haaaa5555, 1'b0, 0);
        set_csr('h12345678, 'haa345578);
        add_row(op_lui, sel_none, 'h11111111, 'hffff0000, 0, 0, 'h11111111, 1'b0, 0);
        set_csr('hdeadbeef, 'hdeadbeef);
    endfunction

    task automatic present(input int idx);
        row_t r;
        r = rows[idx];
        in_valid_i    = 1'b1;
        in_op_i       = r.op;
        in_sel_i      = r.sel;
        in_opnd1_i    = r.opnd1;
        in_opnd2_i    = r.opnd2;
        in_instr_i    = r.instr;
        in_pc_i       = pc_base;
        in_waddr_i    = 5'(idx);
        in_wreg_i     = (r.sel != sel_none);
        in_csr_we_i   = r.csr_we;
        in_csr_addr_i = 14'(idx);
        in_csr_data_i = r.csr_data;
    endtask

    // roughly 70 % ready on the output side
    initial begin
        out_ready_i = 1'b0;
        void'($urandom(32'hd66a_dad9));
        forever begin
            @(negedge clk);
            out_ready_i = ($urandom % 100) < 70;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: only %0d of %0d results after %0d cycles",
                     out_count, rows.size(), cycles);
            $display("Done: errors found");
            $fatal(1, "simulation timed out");
        end
    end

    // each output transfer is matched against the next table row
    always @(posedge clk) begin
        row_t r;
        if (!reset_i && out_valid_o && out_ready_i) begin
            if (out_count >= rows.size()) begin
                $display("an extra result came out after the last table row");
                $display("Done: errors found");
                $fatal(1, "extra output");
            end else begin
                r = rows[out_count];
                check("out_wdata_o", out_wdata_o, r.wdata);
                check("out_mem_addr_o", out_mem_addr_o, r.mem_addr);
                check("out_csr_data_o", out_csr_data_o, r.csr_wdata);
                check("out_branch_o", 32'(out_branch_o), 32'(r.branch));
                check("out_target_o", out_target_o, r.target);
                check("out_pc_o", out_pc_o, pc_base);
                check("out_opnd2_o", out_opnd2_o, r.opnd2);
                check("out_op_o", 32'(out_op_o), 32'(r.op));
                check("out_waddr_o", 32'(out_waddr_o), out_count % 32);
                check("out_wreg_o", 32'(out_wreg_o), 32'(r.sel != sel_none));
                check("out_csr_we_o", 32'(out_csr_we_o), 32'(r.csr_we));
                check("out_csr_addr_o", 32'(out_csr_addr_o), out_count % 16384);
                out_count++;
            end
        end
    end

    initial begin
        reset_i       = 1'b1;
        in_valid_i    = 1'b0;
        in_op_i       = '0;
        in_sel_i      = '0;
        in_opnd1_i    = '0;
        in_opnd2_i    = '0;
        in_instr_i    = '0;
        in_pc_i       = '0;
        in_waddr_i    = '0;
        in_wreg_i     = 1'b0;
        in_csr_we_i   = 1'b0;
        in_csr_addr_i = '0;
        in_csr_data_i = '0;
        build_table();
        cycle_limit = 8 * rows.size() + 100;

        repeat (8) begin
            @(negedge clk);
            check("out_valid_o", 32'(out_valid_o), 0);
            check("in_ready_o", 32'(in_ready_o), 0);
        end
        reset_i = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            present(i);
            @(posedge clk);
            while (!in_ready_o) @(posedge clk);
        end
        @(negedge clk);
        in_valid_i = 1'b0;

        while (out_count < rows.size()) @(negedge clk);
        // a few idle cycles to catch anything duplicated
        repeat (4) @(negedge clk);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/ex_pkg.sv
logic/ex_dispatch_reg.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_mem_reg.sv
logic/ex_stage.sv
tests/ex_stage_tb.sv
